//--- common/mips_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips back end shared definitions
// widths, word and register types, alu function
// and memory kind encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mips_pkg;

   // datapath geometry
   localparam int DATA_W     = 32;
   localparam int BYTE_LANES = 4;
   localparam int REG_IDX_W  = 5;

   // one data word
   typedef logic [DATA_W-1:0] word_t;
   // word address, byte address without bits 1:0
   typedef logic [DATA_W-3:0] waddr_t;
   // architectural register number
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   // bit n enables byte lane n, little endian
   typedef logic [BYTE_LANES-1:0] be_t;

   // alu functions
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLL  = 4'd2,
      ALU_SRL  = 4'd3,
      ALU_SRA  = 4'd4,
      ALU_SLLV = 4'd5,
      ALU_SRLV = 4'd6,
      ALU_SRAV = 4'd7,
      ALU_AND  = 4'd8,
      ALU_OR   = 4'd9,
      ALU_XOR  = 4'd10,
      ALU_NOR  = 4'd11,
      ALU_SLT  = 4'd12,
      ALU_SLTU = 4'd13,
      // hands operand a straight through
      ALU_PASS = 4'd14
   } alu_sel_e;

   // memory access kinds
   typedef enum logic [3:0] {
      MEM_NONE = 4'd0,
      MEM_LB   = 4'd1,
      MEM_LH   = 4'd2,
      MEM_LW   = 4'd3,
      MEM_LBU  = 4'd4,
      MEM_LHU  = 4'd5,
      MEM_SB   = 4'd6,
      MEM_SH   = 4'd7,
      MEM_SW   = 4'd8
   } mem_op_e;

   // true for any kind that writes memory
   function automatic logic is_store(input mem_op_e op);
      return op inside {MEM_SB, MEM_SH, MEM_SW};
   endfunction

endpackage

//--- common/ex_mem_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute to memory stage bundle
// one operation per cycle, valid is a plain strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface ex_mem_if;
   import mips_pkg::*;

   // operation present this cycle
   logic     valid;
   mem_op_e  mem_op;
   // alu output, also the byte address for loads and stores
   word_t    result;
   // rt value for stores
   word_t    store_data;
   reg_idx_t dest;

   // execute side drives everything
   modport src (output valid, mem_op, result, store_data, dest);
   // memory side only listens
   modport dst (input valid, mem_op, result, store_data, dest);

endinterface

//--- execute/mips_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips alu
// fifteen arithmetic, logic, shift and
// compare functions, purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mips_alu (
   input  mips_pkg::alu_sel_e alu_sel,
   input  mips_pkg::word_t    a,
   input  mips_pkg::word_t    b,
   output mips_pkg::word_t    result
);
   import mips_pkg::*;

   // fixed shifts take shamt from the immediate field in b
   logic [4:0] shamt_imm;
   // variable shifts take it from the low bits of a
   logic [4:0] shamt_var;
   logic       lt_signed;
   logic       lt_unsigned;

   assign shamt_imm   = b[10:6];
   assign shamt_var   = a[4:0];
   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb
   begin
      // unused encoding gives zero
      result = '0;
      case (alu_sel)
         ALU_ADD:
            result = a + b;
         ALU_SUB:
            result = a - b;
         // immediate shifts move a
         ALU_SLL:
            result = a << shamt_imm;
         ALU_SRL:
            result = a >> shamt_imm;
         ALU_SRA:
            result = $signed(a) >>> shamt_imm;
         // register shifts move b, amount from a
         ALU_SLLV:
            result = b << shamt_var;
         ALU_SRLV:
            result = b >> shamt_var;
         ALU_SRAV:
            result = $signed(b) >>> shamt_var;
         ALU_AND:
            result = a & b;
         ALU_OR:
            result = a | b;
         ALU_XOR:
            result = a ^ b;
         ALU_NOR:
            result = ~(a | b);
         // compares give 1 or 0
         ALU_SLT:
            result = {{(DATA_W-1){1'b0}}, lt_signed};
         ALU_SLTU:
            result = {{(DATA_W-1){1'b0}}, lt_unsigned};
         ALU_PASS:
            result = a;
         default:
            result = '0;
      endcase
   end

endmodule

//--- execute/execute_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage
// issue register, alu and the register
// that feeds the memory stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module execute_stage (
   input                      clk,
   input                      rst_b,
   input                      issue,
   input  mips_pkg::alu_sel_e alu_sel,
   input  mips_pkg::word_t    op_a,
   input  mips_pkg::word_t    op_b,
   input  mips_pkg::mem_op_e  mem_op,
   input  mips_pkg::word_t    store_data,
   input  mips_pkg::reg_idx_t dest,
   ex_mem_if.src              ex_mem
);
   import mips_pkg::*;

   // issue register contents
   logic     valid_q;
   alu_sel_e alu_sel_q;
   word_t    op_a_q;
   word_t    op_b_q;
   mem_op_e  mem_op_q;
   word_t    store_data_q;
   reg_idx_t dest_q;
   word_t    alu_result;

   // only the valid bits carry reset, payload just follows
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         valid_q      <= 1'b0;
         ex_mem.valid <= 1'b0;
      end
      else
      begin
         valid_q      <= issue;
         ex_mem.valid <= valid_q;
      end
   end

   // edge k, capture the issued operation
   always_ff @(posedge clk)
   begin
      alu_sel_q    <= alu_sel;
      op_a_q       <= op_a;
      op_b_q       <= op_b;
      mem_op_q     <= mem_op;
      store_data_q <= store_data;
      dest_q       <= dest;
   end

   mips_alu u_alu (
      .alu_sel (alu_sel_q),
      .a       (op_a_q),
      .b       (op_b_q),
      .result  (alu_result)
   );

   // edge k+1, result moves on toward memory
   always_ff @(posedge clk)
   begin
      ex_mem.mem_op     <= mem_op_q;
      ex_mem.result     <= alu_result;
      ex_mem.store_data <= store_data_q;
      ex_mem.dest       <= dest_q;
   end

endmodule

//--- memory/store_align.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store alignment
// moves store data into its byte lanes
// and builds the matching enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module store_align (
   input  mips_pkg::mem_op_e mem_op,
   input  logic [1:0]        byte_off,
   input  mips_pkg::word_t   rt_data,
   output mips_pkg::word_t   wdata,
   output mips_pkg::be_t     be
);
   import mips_pkg::*;

   // byte offset scaled to a bit shift
   logic [4:0] bit_off;

   assign bit_off = {byte_off, 3'b000};

   always_comb
   begin
      // non-stores write nothing, data is a don't care
      wdata = rt_data;
      be    = '0;
      case (mem_op)
         MEM_SB:
         begin
            wdata = {24'b0, rt_data[7:0]} << bit_off;
            be    = 4'b0001 << byte_off;
         end
         MEM_SH:
         begin
            // lanes byte_off and byte_off+1
            wdata = {16'b0, rt_data[15:0]} << bit_off;
            be    = 4'b0011 << byte_off;
         end
         MEM_SW:
         begin
            wdata = rt_data;
            be    = '1;
         end
         default:
         begin
            wdata = rt_data;
            be    = '0;
         end
      endcase
   end

endmodule

//--- memory/load_align.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load alignment
// picks a byte or halfword out of the read
// word and sign or zero extends it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module load_align (
   input  mips_pkg::mem_op_e mem_op,
   input  logic [1:0]        byte_off,
   input  mips_pkg::word_t   rdata,
   output mips_pkg::word_t   ldata
);
   import mips_pkg::*;

   // addressed byte lands in lane 0
   word_t shifted;

   assign shifted = rdata >> {byte_off, 3'b000};

   always_comb
   begin
      case (mem_op)
         // signed byte and halfword
         MEM_LB:
            ldata = {{24{shifted[7]}}, shifted[7:0]};
         MEM_LH:
            ldata = {{16{shifted[15]}}, shifted[15:0]};
         // unsigned byte and halfword
         MEM_LBU:
            ldata = {24'b0, shifted[7:0]};
         MEM_LHU:
            ldata = {16'b0, shifted[15:0]};
         // word loads ignore the offset
         MEM_LW:
            ldata = rdata;
         default:
            ldata = rdata;
      endcase
   end

endmodule

//--- memory/memory_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage
// drives the data memory port, selects load
// or alu data, holds the writeback register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module memory_stage (
   input                       clk,
   input                       rst_b,
   input  mips_pkg::word_t     mem_rdata,
   ex_mem_if.dst               ex_mem,
   output mips_pkg::waddr_t    mem_addr,
   output mips_pkg::word_t     mem_wdata,
   output mips_pkg::be_t       mem_be,
   output logic                wb_we,
   output mips_pkg::reg_idx_t  wb_reg,
   output mips_pkg::word_t     wb_data
);
   import mips_pkg::*;

   logic [1:0] byte_off;
   be_t        store_be;
   word_t      load_data;
   logic       is_load;
   word_t      wb_data_d;

   // word address and lane offset both come from the alu result
   assign mem_addr = ex_mem.result[DATA_W-1:2];
   assign byte_off = ex_mem.result[1:0];

   store_align u_store_align (
      .mem_op   (ex_mem.mem_op),
      .byte_off (byte_off),
      .rt_data  (ex_mem.store_data),
      .wdata    (mem_wdata),
      .be       (store_be)
   );

   // a bubble never writes memory
   assign mem_be = ex_mem.valid ? store_be : '0;

   load_align u_load_align (
      .mem_op   (ex_mem.mem_op),
      .byte_off (byte_off),
      .rdata    (mem_rdata),
      .ldata    (load_data)
   );

   assign is_load   = (ex_mem.mem_op != MEM_NONE) && !is_store(ex_mem.mem_op);
   assign wb_data_d = is_load ? load_data : ex_mem.result;

   // edge k+2, everything but stores writes back
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         wb_we <= 1'b0;
      else
         wb_we <= ex_mem.valid && !is_store(ex_mem.mem_op);
   end

   always_ff @(posedge clk)
   begin
      wb_reg  <= ex_mem.dest;
      wb_data <= wb_data_d;
   end

endmodule

//--- src/mips_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips back end top level
// execute, memory and writeback for a stream
// of decoded operations, two cycle latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mips_backend (
   input                       clk,
   input                       rst_b,
   // operation issue, one per cycle, always accepted
   input                       issue,
   input  mips_pkg::alu_sel_e  alu_sel,
   input  mips_pkg::word_t     op_a,
   input  mips_pkg::word_t     op_b,
   input  mips_pkg::mem_op_e   mem_op,
   input  mips_pkg::word_t     store_data,
   input  mips_pkg::reg_idx_t  dest,
   // data memory, read is combinational
   input  mips_pkg::word_t     mem_rdata,
   output mips_pkg::waddr_t    mem_addr,
   output mips_pkg::word_t     mem_wdata,
   output mips_pkg::be_t       mem_be,
   // writeback, in issue order
   output logic                wb_we,
   output mips_pkg::reg_idx_t  wb_reg,
   output mips_pkg::word_t     wb_data
);

   // single bundle between the two stages
   ex_mem_if u_ex_mem ();

   execute_stage u_execute_stage (
      .clk        (clk),
      .rst_b      (rst_b),
      .issue      (issue),
      .alu_sel    (alu_sel),
      .op_a       (op_a),
      .op_b       (op_b),
      .mem_op     (mem_op),
      .store_data (store_data),
      .dest       (dest),
      .ex_mem     (u_ex_mem.src)
   );

   memory_stage u_memory_stage (
      .clk       (clk),
      .rst_b     (rst_b),
      .mem_rdata (mem_rdata),
      .ex_mem    (u_ex_mem.dst),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_be    (mem_be),
      .wb_we     (wb_we),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data)
   );

endmodule

//--- dv/tb_mips_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips back end testbench
// directed tests with a memory model, a
// reference model and a negedge monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_mips_backend;
   import mips_pkg::*;

   localparam int CLK_NS    = 20;
   localparam int RESET_CYC = 16;
   localparam int N_ALU     = 200;
   localparam int N_STREAM  = 30;
   // alu, shift, store, load and streaming operations
   localparam int N_OPS     = N_ALU + 12 + 8 + 15 + N_STREAM;

   // expected writeback and the monitor cycle it is due in
   typedef struct packed {
      int       due;
      reg_idx_t rd;
      word_t    data;
   } wb_exp_t;
   // expected store on the memory port
   typedef struct packed {
      int    due;
      word_t addr;
      be_t   be;
   } st_exp_t;

   logic     clk;
   logic     rst_b;
   logic     issue;
   alu_sel_e alu_sel;
   word_t    op_a;
   word_t    op_b;
   mem_op_e  mem_op;
   word_t    store_data;
   reg_idx_t dest;
   word_t    mem_rdata;
   waddr_t   mem_addr;
   word_t    mem_wdata;
   be_t      mem_be;
   logic     wb_we;
   reg_idx_t wb_reg;
   word_t    wb_data;

   word_t       mem [64];
   word_t       model_mem [64];
   wb_exp_t     wb_q [$];
   st_exp_t     st_q [$];
   int          cyc = 0;
   int          val_errs = 0;
   int          other_errs = 0;
   logic        mon_en = 1'b0;
   string       cur_test = "init";
   logic [31:0] rng_state = 32'hc430_6d21;

   mips_backend u_dut (
      .clk        (clk),
      .rst_b      (rst_b),
      .issue      (issue),
      .alu_sel    (alu_sel),
      .op_a       (op_a),
      .op_b       (op_b),
      .mem_op     (mem_op),
      .store_data (store_data),
      .dest       (dest),
      .mem_rdata  (mem_rdata),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_be     (mem_be),
      .wb_we      (wb_we),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_NS/2) clk = ~clk;
   end

   // data memory with a combinational read
   // lane n is written when be bit n is set
   assign mem_rdata = mem[mem_addr[5:0]];

   always @(posedge clk)
   begin
      for (int n = 0; n < BYTE_LANES; n++)
      begin
         if (mem_be[n])
            mem[mem_addr[5:0]][8*n +: 8] <= mem_wdata[8*n +: 8];
      end
   end

   function automatic word_t next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // initial contents depend on every address bit
   function automatic word_t fill_word(input int idx);
      return 32'h9e37_79b9 * word_t'(idx + 1);
   endfunction

   function automatic word_t alu_model(input alu_sel_e sel, input word_t a, input word_t b);
      logic [63:0] ext;
      int          sh_imm;
      int          sh_var;
      word_t       r;
      // fixed shifts use the shamt field of b, variable shifts the low bits of a
      sh_imm = int'(b[10:6]);
      sh_var = int'(a[4:0]);
      case (sel)
         ALU_ADD:  r = a + b;
         ALU_SUB:  r = a - b;
         ALU_SLL:  r = a << sh_imm;
         ALU_SRL:  r = a >> sh_imm;
         ALU_SLLV: r = b << sh_var;
         ALU_SRLV: r = b >> sh_var;
         ALU_AND:  r = a & b;
         ALU_OR:   r = a | b;
         ALU_XOR:  r = a ^ b;
         ALU_NOR:  r = ~(a | b);
         ALU_PASS: r = a;
         ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
         // signed compare by flipping the sign bits
         ALU_SLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
         ALU_SRA:
         begin
            ext = {{32{a[31]}}, a} >> sh_imm;
            r   = ext[31:0];
         end
         ALU_SRAV:
         begin
            ext = {{32{b[31]}}, b} >> sh_var;
            r   = ext[31:0];
         end
         default:  r = '0;
      endcase
      return r;
   endfunction

   // source byte k lands in lane off+k and lanes past 3 are dropped
   function automatic be_t store_model(input mem_op_e op, input word_t addr, input word_t sd);
      be_t be;
      int  off;
      int  nb;
      int  lane;
      be  = '0;
      off = (op == MEM_SW) ? 0 : int'(addr[1:0]);
      nb  = (op == MEM_SB) ? 1 : ((op == MEM_SH) ? 2 : 4);
      for (int k = 0; k < nb; k++)
      begin
         lane = off + k;
         if (lane < BYTE_LANES)
         begin
            be[lane] = 1'b1;
            model_mem[int'(addr[7:2])][8*lane +: 8] = sd[8*k +: 8];
         end
      end
      return be;
   endfunction

   function automatic word_t load_model(input mem_op_e op, input word_t addr);
      word_t w;
      word_t s;
      w = model_mem[int'(addr[7:2])];
      s = w >> (8 * int'(addr[1:0]));
      case (op)
         MEM_LB:  return {{24{s[7]}}, s[7:0]};
         MEM_LH:  return {{16{s[15]}}, s[15:0]};
         MEM_LBU: return {24'b0, s[7:0]};
         MEM_LHU: return {16'b0, s[15:0]};
         default: return w;
      endcase
   endfunction

   task automatic word_compare(input string what, input word_t exp, input word_t act);
      if (act !== exp)
      begin
         $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp, act);
         val_errs++;
      end
   endtask

   task automatic reg_compare(input reg_idx_t exp, input reg_idx_t act);
      if (act !== exp)
      begin
         $display("ERROR %s wb_reg: expected %0d actual %0d", cur_test, exp, act);
         val_errs++;
      end
   endtask

   task automatic be_compare(input be_t exp, input be_t act);
      if (act !== exp)
      begin
         $display("ERROR %s mem_be: expected %b actual %b", cur_test, exp, act);
         val_errs++;
      end
   endtask

   task automatic report_fail(input string msg);
      $display("%s: %s at cycle %0d", cur_test, msg, cyc);
      other_errs++;
   endtask

   // outputs are settled at the falling edge
   always @(negedge clk)
   begin
      cyc = cyc + 1;
      if (mon_en)
      begin
         if (st_q.size() > 0 && st_q[0].due == cyc)
         begin
            be_compare(st_q[0].be, mem_be);
            word_compare("store address", st_q[0].addr, {mem_addr, 2'b00});
            void'(st_q.pop_front());
         end
         else if (mem_be !== '0)
            report_fail("memory write with no store in flight");
         if (wb_q.size() > 0 && wb_q[0].due == cyc)
         begin
            if (wb_we !== 1'b1)
               report_fail("expected writeback did not appear");
            reg_compare(wb_q[0].rd, wb_reg);
            word_compare("wb_data", wb_q[0].data, wb_data);
            void'(wb_q.pop_front());
         end
         else if (wb_we !== 1'b0)
            report_fail("writeback with no operation due");
      end
   end

   // drive one operation and queue what the model expects from it
   task automatic issue_op(input alu_sel_e sel, input word_t a, input word_t b,
                           input mem_op_e mop, input word_t sd, input reg_idx_t rd);
      word_t   res;
      wb_exp_t w;
      st_exp_t s;
      @(posedge clk);
      issue      <= 1'b1;
      alu_sel    <= sel;
      op_a       <= a;
      op_b       <= b;
      mem_op     <= mop;
      store_data <= sd;
      dest       <= rd;
      res = alu_model(sel, a, b);
      if (is_store(mop))
      begin
         s.due  = cyc + 3;
         s.addr = {res[31:2], 2'b00};
         s.be   = store_model(mop, res, sd);
         st_q.push_back(s);
      end
      else
      begin
         w.due  = cyc + 4;
         w.rd   = rd;
         w.data = (mop == MEM_NONE) ? res : load_model(mop, res);
         wb_q.push_back(w);
      end
   endtask

   // bubbles keep the last payload on the inputs
   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk);
         issue <= 1'b0;
      end
   endtask

   task automatic drain();
      while (wb_q.size() > 0 || st_q.size() > 0)
         idle(1);
      idle(2);
   endtask

   task automatic memory_compare();
      for (int i = 0; i < 64; i++)
         word_compare($sformatf("mem[%0d]", i), model_mem[i], mem[i]);
   endtask

   // issue stays high through reset with stores and alu ops alternating
   task automatic reset_test();
      cur_test = "reset";
      for (int i = 0; i < RESET_CYC; i++)
      begin
         @(posedge clk);
         issue  <= 1'b1;
         mem_op <= (i % 2 == 0) ? MEM_SW : MEM_NONE;
         @(negedge clk);
         be_compare('0, mem_be);
         if (wb_we !== 1'b0)
            report_fail("wb_we raised while in reset");
      end
      @(posedge clk);
      rst_b  <= 1'b1;
      issue  <= 1'b0;
      mem_op <= MEM_NONE;
      mon_en = 1'b1;
      idle(4);
   endtask

   task automatic alu_test();
      alu_sel_e sel;
      cur_test = "alu";
      for (int i = 0; i < N_ALU; i++)
      begin
         sel = alu_sel_e'(4'(next_rand() % 15));
         issue_op(sel, next_rand(), next_rand(), MEM_NONE, next_rand(),
                  reg_idx_t'(next_rand()));
      end
      drain();
   endtask

   // amounts 0 and 31 with junk in the bits that must be ignored
   task automatic shift_test();
      logic [4:0] amt;
      word_t      value;
      word_t      junk;
      cur_test = "shift";
      for (int n = 0; n < 2; n++)
      begin
         amt   = (n == 0) ? 5'd0 : 5'd31;
         value = 32'h8000_0000 | next_rand();
         junk  = next_rand();
         issue_op(ALU_SLL, value, {junk[31:11], amt, junk[5:0]}, MEM_NONE, '0, 5'd1);
         issue_op(ALU_SRL, value, {junk[31:11], amt, junk[5:0]}, MEM_NONE, '0, 5'd2);
         issue_op(ALU_SRA, value, {junk[31:11], amt, junk[5:0]}, MEM_NONE, '0, 5'd3);
         issue_op(ALU_SLLV, {junk[31:5], amt}, value, MEM_NONE, '0, 5'd4);
         issue_op(ALU_SRLV, {junk[31:5], amt}, value, MEM_NONE, '0, 5'd5);
         issue_op(ALU_SRAV, {junk[31:5], amt}, value, MEM_NONE, '0, 5'd6);
      end
      drain();
   endtask

   // sb into words 8 to 11, sh into words 12 to 14, sw into word 15
   task automatic store_test();
      cur_test = "store";
      for (int off = 0; off < 4; off++)
         issue_op(ALU_ADD, 32'd32 + 32'(5 * off), 32'd0, MEM_SB, next_rand(), 5'd0);
      for (int off = 0; off < 3; off++)
         issue_op(ALU_ADD, 32'd48 + 32'(4 * off), 32'(off), MEM_SH, next_rand(), 5'd0);
      issue_op(ALU_PASS, 32'd60, next_rand(), MEM_SW, next_rand(), 5'd0);
      drain();
      memory_compare();
   endtask

   task automatic load_test();
      cur_test = "load";
      for (int off = 0; off < 4; off++)
      begin
         issue_op(ALU_ADD, 32'd32 + 32'(5 * off), 32'd0, MEM_LB, '0, 5'(off + 1));
         issue_op(ALU_ADD, 32'd32 + 32'(5 * off), 32'd0, MEM_LBU, '0, 5'(off + 8));
      end
      for (int off = 0; off < 3; off++)
      begin
         issue_op(ALU_ADD, 32'd48 + 32'(5 * off), 32'd0, MEM_LH, '0, 5'(off + 16));
         issue_op(ALU_ADD, 32'd48 + 32'(5 * off), 32'd0, MEM_LHU, '0, 5'(off + 24));
      end
      issue_op(ALU_ADD, 32'd56, 32'd4, MEM_LW, '0, 5'd31);
      drain();
   endtask

   // mixed traffic in words 16 to 63 with idle gaps
   task automatic stream_test();
      mem_op_e mop;
      word_t   addr;
      int      kind;
      cur_test = "stream";
      for (int i = 0; i < N_STREAM; i++)
      begin
         kind = int'(next_rand() % 3);
         addr = 32'd64 + (next_rand() % 32'd192);
         if (kind == 0)
            mop = MEM_NONE;
         else if (kind == 1)
            mop = mem_op_e'(4'(6 + next_rand() % 3));
         else
            mop = mem_op_e'(4'(1 + next_rand() % 5));
         // halfwords stay inside the word and words are aligned
         if ((mop == MEM_SH || mop == MEM_LH || mop == MEM_LHU) && addr[1:0] == 2'b11)
            addr[0] = 1'b0;
         if (mop == MEM_SW || mop == MEM_LW)
            addr[1:0] = 2'b00;
         if (mop == MEM_NONE)
            issue_op(alu_sel_e'(4'(next_rand() % 15)), next_rand(), next_rand(), mop,
                     next_rand(), reg_idx_t'(next_rand()));
         else
            issue_op(ALU_ADD, addr, 32'd0, mop, next_rand(), reg_idx_t'(next_rand()));
         if (next_rand() % 3 == 0)
            idle(int'(1 + next_rand() % 2));
      end
      drain();
      memory_compare();
   endtask

   initial
   begin
      rst_b      <= 1'b0;
      issue      <= 1'b0;
      alu_sel    <= ALU_ADD;
      op_a       <= '0;
      op_b       <= '0;
      mem_op     <= MEM_NONE;
      store_data <= '0;
      dest       <= '0;
      for (int i = 0; i < 64; i++)
      begin
         mem[i]       <= fill_word(i);
         model_mem[i] = fill_word(i);
      end
      reset_test();
      alu_test();
      shift_test();
      store_test();
      load_test();
      stream_test();
      $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   // watchdog allows twice the cycles the tests need plus margin
   initial
   begin
      #((N_OPS + 40) * CLK_NS * 2);
      $display("timeout: the run did not finish in time");
      $display("sim failed");
      $finish;
   end

endmodule

//--- vlog.f
common/mips_pkg.sv
common/ex_mem_if.sv
execute/mips_alu.sv
execute/execute_stage.sv
memory/store_align.sv
memory/load_align.sv
memory/memory_stage.sv
src/mips_backend.sv
dv/tb_mips_backend.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, fail on a failure line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_mips_backend -Mdir obj_dir -f vlog.f \
   && ./obj_dir/Vtb_mips_backend > sim.log 2>&1 \
   || { echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
